// ==== hdl/icache_cfg_pkg.sv ====
package icache_cfg_pkg;

    // ------------------------------------------------------------
    // cache geometry, 16 KB 4-way
    // ------------------------------------------------------------
    localparam int unsigned PADDR_W    = 32;
    localparam int unsigned LINE_BYTES = 64;
    localparam int unsigned N_WAYS     = 4;
    localparam int unsigned N_SETS     = 64;                  // 16 KB / 4 ways / 64 B
    localparam int unsigned OFFSET_W   = $clog2(LINE_BYTES);  // byte offset in a line
    localparam int unsigned INDEX_W    = $clog2(N_SETS);
    localparam int unsigned TAG_W      = PADDR_W - INDEX_W - OFFSET_W;

    // fetch word and line widths
    localparam int unsigned FETCH_W    = 128;
    localparam int unsigned LINE_W     = LINE_BYTES * 8;
    localparam int unsigned WORD_SEL_W = $clog2(LINE_W / FETCH_W);  // paddr[5:4]

    // ------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------
    typedef logic [PADDR_W-1:0]        paddr_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;

    // way number and one bit per way
    typedef logic [$clog2(N_WAYS)-1:0] way_t;
    typedef logic [N_WAYS-1:0]         way_mask_t;

    typedef logic [FETCH_W-1:0]        fetch_t;
    typedef logic [LINE_W-1:0]         line_t;

endpackage

// ==== hdl/icache_bus_pkg.sv ====
package icache_bus_pkg;

    import icache_cfg_pkg::*;

    // ------------------------------------------------------------
    // core, next-level and internal channels
    // ------------------------------------------------------------
    typedef struct packed {
        paddr_t paddr;
    } core_req_t;

    typedef struct packed {
        fetch_t data;
        paddr_t paddr;    // address the word was fetched for
    } core_resp_t;

    typedef struct packed {
        paddr_t paddr;    // low offset bits always zero
    } fill_req_t;

    typedef struct packed {
        line_t line;
    } fill_resp_t;

    typedef struct packed {
        index_t index;
    } inval_req_t;

    // lookup to refill on a miss
    typedef struct packed {
        paddr_t    paddr;
        way_mask_t valid;   // valid bits of the set at lookup time
    } miss_t;

    // ------------------------------------------------------------
    // shared array ports
    // ------------------------------------------------------------
    typedef struct packed {
        index_t index;
    } arr_rd_t;

    typedef struct packed {
        index_t index;
        way_t   way;
        tag_t   tag;
        line_t  line;
        logic   inval;    // clear the whole set, tag and line ignored
    } arr_wr_t;

    typedef struct packed {
        tag_t  [N_WAYS-1:0] tags;
        line_t [N_WAYS-1:0] lines;
        way_mask_t          valid;
    } arr_rdata_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_READ,
        LK_COMPARE,
        LK_WAIT_FILL
    } lookup_state_e;

    typedef enum logic [2:0] {
        RF_IDLE,
        RF_REQUEST,
        RF_WAIT_LINE,
        RF_WRITE,
        RF_DONE
    } refill_state_e;

endpackage

// ==== hdl/icache_array.sv ====
module icache_array
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       flush_i,
    // read port
    input  logic       rd_valid_i,
    input  arr_rd_t    rd_i,
    // write port
    input  logic       wr_valid_i,
    input  arr_wr_t    wr_i,
    output arr_rdata_t rdata_o
);

    tag_t  tag_mem  [N_WAYS][N_SETS];
    line_t data_mem [N_WAYS][N_SETS];

    way_mask_t [N_SETS-1:0] valid_q;   // one bit per set and way

    tag_t  [N_WAYS-1:0] tags_rd_q;
    line_t [N_WAYS-1:0] lines_rd_q;
    way_mask_t          valid_rd_q;

    // ------------------------------------------------------------
    // tag and data memories
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_valid_i && !wr_i.inval) begin
            tag_mem[wr_i.way][wr_i.index]  <= wr_i.tag;
            data_mem[wr_i.way][wr_i.index] <= wr_i.line;
        end
        if (rd_valid_i) begin
            // all ways read in parallel
            for (int w = 0; w < N_WAYS; w++) begin
                tags_rd_q[w]  <= tag_mem[w][rd_i.index];
                lines_rd_q[w] <= data_mem[w][rd_i.index];
            end
        end
    end

    // ------------------------------------------------------------
    // valid bits
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                         // flush wins over a same-cycle write
        end else if (wr_valid_i) begin
            if (wr_i.inval) begin
                valid_q[wr_i.index] <= '0;         // whole set
            end else begin
                valid_q[wr_i.index][wr_i.way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_rd_q <= '0;
        end else if (rd_valid_i) begin
            valid_rd_q <= valid_q[rd_i.index];
        end
    end

    assign rdata_o = '{tags: tags_rd_q, lines: lines_rd_q, valid: valid_rd_q};

    // single array port shared by lookup and refill
    a_no_rd_wr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(rd_valid_i && wr_valid_i));

endmodule

// ==== hdl/icache_array_arb.sv ====
module icache_array_arb
    import icache_bus_pkg::*;
(
    // lookup side reads only
    input  logic    lookup_req_i,
    input  arr_rd_t lookup_rd_i,
    output logic    lookup_gnt_o,
    // refill side for writes and invalidations
    input  logic    refill_req_i,
    input  arr_wr_t refill_wr_i,
    output logic    refill_gnt_o,
    // towards the array
    output logic    arr_rd_valid_o,
    output arr_rd_t arr_rd_o,
    output logic    arr_wr_valid_o,
    output arr_wr_t arr_wr_o
);

    // ------------------------------------------------------------
    // fixed priority with refill first
    // ------------------------------------------------------------
    // a pending fill or invalidation is never starved by replays
    // because the lookup only retries its read
    always_comb begin
        refill_gnt_o = refill_req_i;
        lookup_gnt_o = lookup_req_i && !refill_req_i;
    end

    // ------------------------------------------------------------
    // steer the winner onto the array
    // ------------------------------------------------------------
    always_comb begin
        arr_rd_valid_o = 1'b0;
        arr_wr_valid_o = 1'b0;
        arr_rd_o       = lookup_rd_i;
        arr_wr_o       = refill_wr_i;

        if (refill_gnt_o) begin
            arr_wr_valid_o = 1'b1;
        end else if (lookup_gnt_o) begin
            arr_rd_valid_o = 1'b1;
        end
    end

endmodule

// ==== hdl/icache_lookup.sv ====
module icache_lookup
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    // core request
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  core_req_t  req_i,
    // core response
    output logic       resp_valid_o,
    input  logic       resp_ready_i,
    output core_resp_t resp_o,
    // shared array
    output logic       arr_req_o,
    output arr_rd_t    arr_rd_o,
    input  logic       arr_gnt_i,
    input  arr_rdata_t rdata_i,
    // miss hand-off to refill
    output logic       miss_valid_o,
    input  logic       miss_ready_i,
    output miss_t      miss_o,
    input  logic       fill_done_i
);

    lookup_state_e state_q;
    lookup_state_e state_d;

    core_req_t req_q;              // request in flight
    tag_t      req_tag;
    logic      hit;
    way_t      hit_way;

    fetch_t [2**WORD_SEL_W-1:0] hit_words;

    assign req_tag = req_q.paddr[PADDR_W-1 -: TAG_W];

    // ------------------------------------------------------------
    // tag compare and word select
    // ------------------------------------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (rdata_i.valid[w] && (rdata_i.tags[w] == req_tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_words = rdata_i.lines[hit_way];

    // read data is held by the array until the next read
    assign resp_o = '{
        data:  hit_words[req_q.paddr[OFFSET_W-1 -: WORD_SEL_W]],
        paddr: req_q.paddr
    };

    assign arr_rd_o = '{index: req_q.paddr[OFFSET_W +: INDEX_W]};
    assign miss_o   = '{paddr: req_q.paddr, valid: rdata_i.valid};

    // ------------------------------------------------------------
    // lookup FSM
    // ------------------------------------------------------------
    always_comb begin
        state_d      = state_q;
        req_ready_o  = 1'b0;
        arr_req_o    = 1'b0;
        resp_valid_o = 1'b0;
        miss_valid_o = 1'b0;

        unique case (state_q)
            LK_IDLE: begin
                req_ready_o = 1'b1;
                if (req_valid_i) state_d = LK_READ;
            end
            LK_READ: begin
                arr_req_o = 1'b1;                     // retried until granted
                if (arr_gnt_i) state_d = LK_COMPARE;
            end
            LK_COMPARE: begin
                resp_valid_o = hit;
                miss_valid_o = !hit;
                if (hit && resp_ready_i) begin
                    state_d = LK_IDLE;
                end else if (!hit && miss_ready_i) begin
                    state_d = LK_WAIT_FILL;
                end
            end
            LK_WAIT_FILL: begin
                if (fill_done_i) state_d = LK_READ;   // replay, now hits
            end
            default: state_d = LK_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= LK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) req_q <= req_i;
    end

    // holds across modules, the word comes straight from the array read register
    a_resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== hdl/icache_refill.sv ====
module icache_refill
    import icache_cfg_pkg::*, icache_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    // miss from lookup
    input  logic       miss_valid_i,
    output logic       miss_ready_o,
    input  miss_t      miss_i,
    output logic       fill_done_o,
    // next level
    output logic       fill_req_valid_o,
    input  logic       fill_req_ready_i,
    output fill_req_t  fill_req_o,
    input  logic       fill_resp_valid_i,
    input  fill_resp_t fill_resp_i,
    input  logic       inval_valid_i,
    output logic       inval_ready_o,
    input  inval_req_t inval_i,
    // shared array
    output logic       arr_req_o,
    output arr_wr_t    arr_wr_o,
    input  logic       arr_gnt_i
);

    refill_state_e state_q;
    refill_state_e state_d;

    logic      is_inval_q;         // current write is a set invalidation
    tag_t      tag_q;
    index_t    idx_q;
    way_mask_t vmask_q;
    line_t     line_q;

    way_t [N_SETS-1:0] rr_q;       // round-robin pointer per set
    way_t      victim;
    logic      inval_acc;
    logic      miss_acc;
    logic      wr_done;

    // invalidation first, the miss waits one cycle
    assign inval_ready_o = (state_q == RF_IDLE);
    assign miss_ready_o  = (state_q == RF_IDLE) && !inval_valid_i;
    assign inval_acc     = inval_valid_i && inval_ready_o;
    assign miss_acc      = miss_valid_i && miss_ready_o;
    assign wr_done       = arr_req_o && arr_gnt_i;

    // ------------------------------------------------------------
    // victim, lowest invalid way else round robin
    // ------------------------------------------------------------
    always_comb begin
        victim = rr_q[idx_q];
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (!vmask_q[w]) victim = way_t'(w);
        end
    end

    assign fill_req_valid_o = (state_q == RF_REQUEST);
    assign arr_req_o        = (state_q == RF_WRITE);
    assign fill_done_o      = (state_q == RF_DONE);

    assign fill_req_o = '{paddr: {tag_q, idx_q, {OFFSET_W{1'b0}}}};
    assign arr_wr_o   = '{index: idx_q, way: victim, tag: tag_q,
                          line: line_q, inval: is_inval_q};

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RF_IDLE: begin
                if (inval_acc) begin
                    state_d = RF_WRITE;
                end else if (miss_acc) begin
                    state_d = RF_REQUEST;
                end
            end
            RF_REQUEST:   if (fill_req_ready_i) state_d = RF_WAIT_LINE;
            RF_WAIT_LINE: if (fill_resp_valid_i) state_d = RF_WRITE;
            RF_WRITE:     if (arr_gnt_i) state_d = is_inval_q ? RF_IDLE : RF_DONE;
            RF_DONE:      state_d = RF_IDLE;    // fill_done pulse
            default:      state_d = RF_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= RF_IDLE;
            is_inval_q <= 1'b0;
            rr_q       <= '0;
        end else begin
            state_q <= state_d;
            if (inval_acc) begin
                is_inval_q <= 1'b1;
            end else if (miss_acc) begin
                is_inval_q <= 1'b0;
            end
            if (wr_done && !is_inval_q && (&vmask_q)) begin
                rr_q[idx_q] <= rr_q[idx_q] + 1'b1;   // advance only on replacement
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (inval_acc) begin
            idx_q <= inval_i.index;
        end else if (miss_acc) begin
            tag_q   <= miss_i.paddr[PADDR_W-1 -: TAG_W];
            idx_q   <= miss_i.paddr[OFFSET_W +: INDEX_W];
            vmask_q <= miss_i.valid;
        end
        if ((state_q == RF_WAIT_LINE) && fill_resp_valid_i) line_q <= fill_resp_i.line;
    end

    a_fill_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fill_req_valid_o && !fill_req_ready_i |=> fill_req_valid_o && $stable(fill_req_o));

endmodule

// ==== hdl/icache_top.sv ====
module icache_top
    import icache_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       flush_i,
    // core
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  core_req_t  req_i,
    output logic       resp_valid_o,
    input  logic       resp_ready_i,
    output core_resp_t resp_o,
    // next level
    output logic       fill_req_valid_o,
    input  logic       fill_req_ready_i,
    output fill_req_t  fill_req_o,
    input  logic       fill_resp_valid_i,
    input  fill_resp_t fill_resp_i,
    input  logic       inval_valid_i,
    output logic       inval_ready_o,
    input  inval_req_t inval_i
);

    logic       miss_valid, miss_ready, fill_done;
    miss_t      miss;
    logic       lk_arr_req, lk_arr_gnt, rf_arr_req, rf_arr_gnt;
    arr_rd_t    lk_arr_rd, arr_rd;
    arr_wr_t    rf_arr_wr, arr_wr;
    logic       arr_rd_valid, arr_wr_valid;
    arr_rdata_t arr_rdata;

    icache_lookup u_lookup (
        .clk_i, .arst_n_i, .req_valid_i, .req_ready_o, .req_i,
        .resp_valid_o, .resp_ready_i, .resp_o,
        .arr_req_o (lk_arr_req), .arr_rd_o (lk_arr_rd), .arr_gnt_i (lk_arr_gnt),
        .rdata_i (arr_rdata), .miss_valid_o (miss_valid), .miss_ready_i (miss_ready),
        .miss_o (miss), .fill_done_i (fill_done)
    );

    icache_refill u_refill (
        .clk_i, .arst_n_i, .miss_valid_i (miss_valid), .miss_ready_o (miss_ready),
        .miss_i (miss), .fill_done_o (fill_done),
        .fill_req_valid_o, .fill_req_ready_i, .fill_req_o,
        .fill_resp_valid_i, .fill_resp_i, .inval_valid_i, .inval_ready_o, .inval_i,
        .arr_req_o (rf_arr_req), .arr_wr_o (rf_arr_wr), .arr_gnt_i (rf_arr_gnt)
    );

    icache_array_arb u_arb (
        .lookup_req_i (lk_arr_req), .lookup_rd_i (lk_arr_rd), .lookup_gnt_o (lk_arr_gnt),
        .refill_req_i (rf_arr_req), .refill_wr_i (rf_arr_wr), .refill_gnt_o (rf_arr_gnt),
        .arr_rd_valid_o (arr_rd_valid), .arr_rd_o (arr_rd),
        .arr_wr_valid_o (arr_wr_valid), .arr_wr_o (arr_wr)
    );

    icache_array u_array (
        .clk_i, .arst_n_i, .flush_i,
        .rd_valid_i (arr_rd_valid), .rd_i (arr_rd),
        .wr_valid_i (arr_wr_valid), .wr_i (arr_wr), .rdata_o (arr_rdata)
    );

endmodule

// ==== sim/tb_icache.sv ====
module tb_icache
    import icache_cfg_pkg::*, icache_bus_pkg::*;
();

    localparam int unsigned MAX_OPS    = 64;
    localparam int unsigned RESET_CYC  = 16;
    localparam logic [31:0] MEM_XOR    = 32'hA5A5_0000;   // memory content rule

    logic       clk_i;
    logic       arst_n_i;
    logic       flush_i;
    logic       req_valid_i;
    logic       req_ready_o;
    core_req_t  req_i;
    logic       resp_valid_o;
    logic       resp_ready_i;
    core_resp_t resp_o;
    logic       fill_req_valid_o;
    logic       fill_req_ready_i;
    fill_req_t  fill_req_o;
    logic       fill_resp_valid_i;
    fill_resp_t fill_resp_i;
    logic       inval_valid_i;
    logic       inval_ready_o;
    inval_req_t inval_i;

    logic [31:0] stim [3*MAX_OPS];   // opcode, argument, expected miss
    int          n_ops;
    int          n_fills;            // fill requests seen by the memory model
    paddr_t      last_fill_addr;
    logic [31:0] rng_q;

    icache_top dut (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .flush_i           (flush_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .req_i             (req_i),
        .resp_valid_o      (resp_valid_o),
        .resp_ready_i      (resp_ready_i),
        .resp_o            (resp_o),
        .fill_req_valid_o  (fill_req_valid_o),
        .fill_req_ready_i  (fill_req_ready_i),
        .fill_req_o        (fill_req_o),
        .fill_resp_valid_i (fill_resp_valid_i),
        .fill_resp_i       (fill_resp_i),
        .inval_valid_i     (inval_valid_i),
        .inval_ready_o     (inval_ready_o),
        .inval_i           (inval_i)
    );

    always #4 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_q = rng_q ^ (rng_q << 13);
        rng_q = rng_q ^ (rng_q >> 17);
        rng_q = rng_q ^ (rng_q << 5);
        return rng_q;
    endfunction

    // every 32-bit word holds its byte address xor a constant
    function automatic line_t line_from_memory(input paddr_t addr);
        line_t  line;
        paddr_t base;
        base = {addr[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        for (int i = 0; i < LINE_W / 32; i++) begin
            line[i*32 +: 32] = (base + 32'(4 * i)) ^ MEM_XOR;
        end
        return line;
    endfunction

    function automatic fetch_t word_from_memory(input paddr_t addr);
        fetch_t word;
        paddr_t base;
        base = {addr[PADDR_W-1:4], 4'h0};     // 16-byte aligned fetch word
        for (int i = 0; i < FETCH_W / 32; i++) begin
            word[i*32 +: 32] = (base + 32'(4 * i)) ^ MEM_XOR;
        end
        return word;
    endfunction

    task automatic check_equal(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    // all tasks start and end just after a rising edge
    task automatic fetch_and_check(input paddr_t addr, input logic exp_miss);
        int         fills_before;
        logic       done;
        core_resp_t resp;
        fills_before = n_fills;
        req_valid_i  = 1'b1;
        req_i.paddr  = addr;
        do begin
            @(negedge clk_i);
            done = req_ready_o;              // accepted on the coming edge
            @(posedge clk_i);
            #1;
        end while (!done);
        req_valid_i = 1'b0;
        req_i       = '0;
        do begin
            @(negedge clk_i);
            done = resp_valid_o && resp_ready_i;
            resp = resp_o;
            @(posedge clk_i);
            #1;
        end while (!done);
        check_equal("response address", resp.paddr, addr);
        check_equal("response data", resp.data, word_from_memory(addr));
        check_equal("fill requests", n_fills - fills_before, exp_miss);
        if (exp_miss) begin
            check_equal("fill address", last_fill_addr,
                        {addr[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        end
    endtask

    task automatic invalidate_set(input index_t idx);
        logic done;
        inval_valid_i = 1'b1;
        inval_i.index = idx;
        do begin
            @(negedge clk_i);
            done = inval_ready_o;
            @(posedge clk_i);
            #1;
        end while (!done);
        inval_valid_i = 1'b0;
    endtask

    task automatic pulse_flush();
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
    endtask

    // ------------------------------------------------------------
    // next-level memory model
    // ------------------------------------------------------------
    always begin : next_level_model
        paddr_t      addr;
        int unsigned delay;
        @(negedge clk_i);
        if (fill_req_valid_o && fill_req_ready_i) begin
            addr           = fill_req_o.paddr;
            last_fill_addr = addr;
            n_fills        = n_fills + 1;
            delay          = next_random() % 4;    // 0 to 3 cycles
            @(posedge clk_i);
            #1;
            repeat (delay) begin
                @(posedge clk_i);
                #1;
            end
            fill_resp_i.line  = line_from_memory(addr);
            fill_resp_valid_i = 1'b1;
            @(posedge clk_i);
            #1;
            fill_resp_valid_i = 1'b0;
        end
    end

    // random back-pressure on both ready inputs
    always begin : ready_driver
        logic [31:0] r;
        @(posedge clk_i);
        #1;
        r                = next_random();
        resp_ready_i     = (r[1:0] != 2'b00);
        fill_req_ready_i = (r[3:2] != 2'b00);
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin : watchdog
        wait (n_ops != 0);
        repeat (RESET_CYC + 200 * n_ops) @(posedge clk_i);
        $display("the cache stopped responding before the stimulus was done");
        $display("TEST FAILED");
        $fatal(1);
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin : main
        int          op;
        int          count;
        logic [31:0] arg;
        logic        exp_miss;
        clk_i             = 1'b0;
        arst_n_i          = 1'b0;
        flush_i           = 1'b0;
        req_valid_i       = 1'b0;
        req_i             = '0;
        resp_ready_i      = 1'b0;
        fill_req_ready_i  = 1'b0;
        fill_resp_valid_i = 1'b0;
        fill_resp_i       = '0;
        inval_valid_i     = 1'b0;
        inval_i           = '0;
        n_fills           = 0;
        last_fill_addr    = '0;
        rng_q             = 32'd54;

        foreach (stim[i]) stim[i] = '1;      // all ones marks the end
        $readmemh("sim/icache_stimulus.txt", stim);
        count = 0;
        while (count < MAX_OPS && stim[3*count] !== '1) begin
            count = count + 1;
        end
        n_ops = count;

        if (n_ops == 0) begin
            $display("the stimulus file could not be read or holds no operations");
            $display("TEST FAILED");
            $fatal(1);
        end else begin
            repeat (RESET_CYC) @(posedge clk_i);
            #1;
            arst_n_i = 1'b1;
            @(posedge clk_i);
            #1;
            for (int i = 0; i < n_ops; i++) begin
                op       = int'(stim[3*i]);
                arg      = stim[3*i + 1];
                exp_miss = stim[3*i + 2][0];
                case (op)
                    0: fetch_and_check(arg, exp_miss);
                    1: invalidate_set(index_t'(arg));
                    2: pulse_flush();
                    default: begin
                        $display("stimulus line %0d has an unknown opcode %0d", i, op);
                        $display("TEST FAILED");
                        $fatal(1);
                    end
                endcase
            end
            repeat (4) @(posedge clk_i);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== sim/icache_stimulus.txt ====
// opcode (0 read, 1 invalidate set, 2 flush), address or set index, expected miss
// one operation per line, hex
0 00000040 1
0 00000070 0
0 00000050 0
// five lines in set 2, then the evicted ones come back
0 00000080 1
0 00001090 1
0 000020a0 1
0 000030b0 1
0 00004080 1
0 00000080 1
0 000020a0 0
0 00004090 0
0 000010b0 1
// set invalidation
1 00000001 0
0 00000060 1
0 00000040 0
// flush
2 00000000 0
0 00000040 1
0 00004080 1
0 000010b0 1
0 00004080 0
0 000010b0 0
0 00000070 0
// other sets
0 0000abc0 1
0 0000abd0 0
0 0000abf0 0
0 12345600 1
0 12345630 0

// ==== tb.f ====
hdl/icache_cfg_pkg.sv
hdl/icache_bus_pkg.sv
hdl/icache_array.sv
hdl/icache_array_arb.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_top.sv
sim/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - hdl/icache_cfg_pkg.sv
      - hdl/icache_bus_pkg.sv
      - hdl/icache_array.sv
      - hdl/icache_array_arb.sv
      - hdl/icache_lookup.sv
      - hdl/icache_refill.sv
      - hdl/icache_top.sv
  - target: simulation
    files:
      - sim/tb_icache.sv
